// File: all.f
design/lbus_align_pkg.sv
design/lbus_seg_buffer.sv
design/lbus_align_ctrl.sv
design/lbus_lane_shifter.sv
design/lbus_out_stage.sv
design/lbus_aligner_top.sv
verification/lbus_align_checker.sv
verification/tb_lbus_aligner.sv

// File: design/lbus_align_ctrl.sv
/*
  lbus alignment controller
  tracks lane offset of the packet in flight and decides buffer pops
*/
`timescale 1ns/1ns

module lbus_align_ctrl
  import lbus_align_pkg::*;
(
  input  logic        CLK,
  input  logic        user_rst,
  input  logic        head_valid,
  input  lbus_beat_t  head_beat,
  input  logic        out_ready,
  output logic        pop,
  output align_mode_t mode,
  output lane_ofs_t   ofs
);

  logic [NUM_SEG-1:0] sop_vec;
  logic [NUM_SEG-1:0] end_vec;
  logic               has_sop;
  logic               has_end;
  lane_ofs_t          sop_lane;
  lane_ofs_t          end_lane;  // first end in the head beat
  logic               late_end;  // end at or after the sop lane
  logic               prev_end;  // popped beat already closes the packet
  logic               prev_end_nxt;
  align_mode_t        mode_nxt;
  lane_ofs_t          ofs_nxt;

  always_comb begin
    for (int i = 0; i < NUM_SEG; i++) begin
      sop_vec[i] = is_sop(head_beat[i]);
      end_vec[i] = is_end(head_beat[i]);
    end
  end

  assign has_sop = |sop_vec;
  assign has_end = |end_vec;

  always_comb begin
    sop_lane = '0;
    end_lane = '0;
    late_end = 1'b0;
    for (int i = NUM_SEG - 1; i >= 0; i--) begin
      if (end_vec[i]) end_lane = 2'(i);
      if (sop_vec[i]) sop_lane = 2'(i);
    end
    for (int i = 0; i < NUM_SEG; i++) begin
      if (end_vec[i] && 2'(i) >= sop_lane) late_end = 1'b1;
    end
  end

  always_comb begin
    pop          = 1'b0;
    mode_nxt     = mode;
    ofs_nxt      = ofs;
    prev_end_nxt = prev_end;
    case (mode)
      IDLE: begin
        if (head_valid && sop_vec[0]) begin
          if (out_ready) begin  // aligned already, goes out as is
            pop      = 1'b1;
            mode_nxt = has_end ? IDLE : IN_BURST;
          end
        end else if (head_valid) begin
          pop = 1'b1;  // empty lanes or a tail already flushed
          if (has_sop) begin
            mode_nxt     = FIRST_PART;
            ofs_nxt      = sop_lane;
            prev_end_nxt = late_end;
          end
        end
      end
      TAIL_FLUSH: begin
        // head stays, idle pops it next
        if (head_valid && out_ready) begin
          mode_nxt = IDLE;
          ofs_nxt  = '0;
        end
      end
      default: begin
        if (ofs != '0 && prev_end) begin
          // short packet sits entirely in prev lanes, no head needed
          if (out_ready) begin
            mode_nxt     = IDLE;
            ofs_nxt      = '0;
            prev_end_nxt = 1'b0;
          end
        end else if (head_valid && out_ready) begin
          if (!has_end) begin
            pop      = 1'b1;
            mode_nxt = IN_BURST;
          end else if (ofs != '0 && end_lane >= ofs) begin
            mode_nxt = TAIL_FLUSH;  // tail spills past the merged beat
          end else begin
            pop = 1'b1;
            if (has_sop) begin
              mode_nxt     = FIRST_PART;
              ofs_nxt      = sop_lane;
              prev_end_nxt = late_end;
            end else begin
              mode_nxt     = IDLE;
              ofs_nxt      = '0;
              prev_end_nxt = 1'b0;
            end
          end
        end
      end
    endcase
  end

  always_ff @(posedge CLK or posedge user_rst) begin
    if (user_rst) begin
      mode     <= IDLE;
      ofs      <= '0;
      prev_end <= 1'b0;
    end else begin
      mode     <= mode_nxt;
      ofs      <= ofs_nxt;
      prev_end <= prev_end_nxt;
    end
  end

  a_one_sop: assert property (@(posedge CLK) disable iff (user_rst)
    head_valid |-> $countones(sop_vec) <= 1)
    else $error("head beat carries more than one SOP");

endmodule

// File: design/lbus_align_pkg.sv
/*
  lbus aligner shared types
  segment and beat layout, lane offset, controller states, default sizes
*/
package lbus_align_pkg;

  localparam int NUM_SEG       = 4;  // lane decode assumes four
  localparam int SEG_W_DEF     = 32;
  localparam int BUF_DEPTH_DEF = 8;

  // one lbus segment, 8 control bits plus data
  typedef struct packed {
    logic                 en;
    logic                 sop;
    logic                 eop;
    logic                 err;
    logic [3:0]           mty;
    logic [SEG_W_DEF-1:0] data;
  } lbus_seg_t;

  // lane 0 first in time
  typedef lbus_seg_t [NUM_SEG-1:0] lbus_beat_t;

  typedef logic [1:0] lane_ofs_t;

  typedef enum logic [1:0] {
    IDLE,
    IN_BURST,
    FIRST_PART,  // packet began mid-beat
    TAIL_FLUSH   // leftover lanes after an end, sent alone
  } align_mode_t;

  function automatic logic is_sop(lbus_seg_t s);
    return s.en && s.sop;
  endfunction

  // err closes a packet just like eop
  function automatic logic is_end(lbus_seg_t s);
    return s.en && (s.eop || s.err);
  endfunction

endpackage

// File: design/lbus_aligner_top.sv
/*
  lbus receive aligner
  repacks four lane lbus so every packet starts in lane 0
*/
`timescale 1ns/1ns

module lbus_aligner_top
  import lbus_align_pkg::*;
#(
  parameter int SEG_W     = SEG_W_DEF,
  parameter int BUF_DEPTH = BUF_DEPTH_DEF
) (
  input  logic       CLK,
  input  logic       user_rst,
  input  logic       in_valid,
  input  lbus_beat_t in_beat,
  output logic       in_credit,
  input  logic       out_credit,
  output logic       out_valid,
  output lbus_beat_t out_beat
);

  logic        head_valid;
  lbus_beat_t  head_beat;
  lbus_beat_t  prev_beat;
  logic        pop;
  logic        out_ready;
  align_mode_t mode;
  lane_ofs_t   ofs;
  logic        merged_valid;
  lbus_beat_t  merged_beat;

  lbus_seg_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_buffer (
    .CLK        (CLK),
    .user_rst   (user_rst),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .pop        (pop),
    .head_valid (head_valid),
    .head_beat  (head_beat),
    .prev_beat  (prev_beat),
    .in_credit  (in_credit)
  );

  lbus_align_ctrl u_ctrl (
    .CLK        (CLK),
    .user_rst   (user_rst),
    .head_valid (head_valid),
    .head_beat  (head_beat),
    .out_ready  (out_ready),
    .pop        (pop),
    .mode       (mode),
    .ofs        (ofs)
  );

  lbus_lane_shifter u_shifter (
    .mode         (mode),
    .ofs          (ofs),
    .head_valid   (head_valid),
    .head_beat    (head_beat),
    .prev_beat    (prev_beat),
    .merged_valid (merged_valid),
    .merged_beat  (merged_beat)
  );

  lbus_out_stage #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_out (
    .CLK          (CLK),
    .user_rst     (user_rst),
    .merged_valid (merged_valid),
    .merged_beat  (merged_beat),
    .out_credit   (out_credit),
    .out_ready    (out_ready),
    .out_valid    (out_valid),
    .out_beat     (out_beat)
  );

  // segment struct is built at the package width
  a_seg_width: assert property (@(posedge CLK) SEG_W == SEG_W_DEF)
    else $fatal(1, "SEG_W must equal SEG_W_DEF");

endmodule

// File: design/lbus_lane_shifter.sv
/*
  lbus lane shifter
  picks four lanes out of prev and head beats at the current offset
*/
`timescale 1ns/1ns

module lbus_lane_shifter
  import lbus_align_pkg::*;
(
  input  align_mode_t mode,
  input  lane_ofs_t   ofs,
  input  logic        head_valid,
  input  lbus_beat_t  head_beat,
  input  lbus_beat_t  prev_beat,
  output logic        merged_valid,
  output lbus_beat_t  merged_beat
);

  lbus_beat_t                head_m;
  lbus_seg_t [2*NUM_SEG-1:0] win;   // prev lanes 0..3, head lanes 4..7
  logic [2:0]                base;  // first window lane of the output
  logic [3:0]                idx;
  logic                      stop;
  logic                      prev_end;

  assign head_m = head_valid ? head_beat : '0;
  assign win    = {head_m, prev_beat};

  always_comb begin
    if (mode == TAIL_FLUSH)
      base = {1'b1, ofs};  // head lanes past the end
    else if (ofs == '0)
      base = 3'(NUM_SEG);
    else
      base = {1'b0, ofs};
  end

  always_comb begin
    prev_end = 1'b0;
    for (int i = 0; i < NUM_SEG; i++) begin
      if (2'(i) >= ofs && is_end(prev_beat[i])) prev_end = 1'b1;
    end
  end

  // copy lanes until the packet ends or the next one starts
  always_comb begin
    stop        = 1'b0;
    idx         = '0;
    merged_beat = '0;
    for (int i = 0; i < NUM_SEG; i++) begin
      idx = {1'b0, base} + 4'(i);
      if (idx < 4'(2 * NUM_SEG) && !stop) begin
        if (i > 0 && is_sop(win[idx[2:0]])) begin
          stop = 1'b1;  // later packet, left for its own beat
        end else begin
          if (win[idx[2:0]].en) merged_beat[i] = win[idx[2:0]];
          if (is_end(win[idx[2:0]])) stop = 1'b1;
        end
      end
    end
  end

  always_comb begin
    case (mode)
      IDLE:       merged_valid = head_valid && is_sop(head_beat[0]);
      TAIL_FLUSH: merged_valid = head_valid;
      default:    merged_valid = head_valid || (ofs != '0 && prev_end);
    endcase
  end

endmodule

// File: design/lbus_out_stage.sv
/*
  lbus output stage
  beat register and downstream credit counter
*/
`timescale 1ns/1ns

module lbus_out_stage
  import lbus_align_pkg::*;
#(
  parameter int BUF_DEPTH = BUF_DEPTH_DEF  // downstream slots, max credits held
) (
  input  logic       CLK,
  input  logic       user_rst,
  input  logic       merged_valid,
  input  lbus_beat_t merged_beat,
  input  logic       out_credit,
  output logic       out_ready,
  output logic       out_valid,
  output lbus_beat_t out_beat
);

  localparam int CW = $clog2(BUF_DEPTH + 1);

  logic [CW-1:0] credits;
  logic          take;

  assign out_ready = credits != '0;
  assign take      = merged_valid && out_ready;

  always_ff @(posedge CLK or posedge user_rst) begin
    if (user_rst) begin
      credits   <= '0;
      out_valid <= 1'b0;
    end else begin
      credits   <= credits + CW'(out_credit) - CW'(take);  // grant and spend may coincide
      out_valid <= take;
    end
  end

  always_ff @(posedge CLK) begin
    if (take) begin
      out_beat <= merged_beat;
    end
  end

  // a wrap below zero shows up as a count above BUF_DEPTH
  a_credit_range: assert property (@(posedge CLK) disable iff (user_rst)
    credits <= CW'(BUF_DEPTH))
    else $error("output credit counter underflow or overgrant");

endmodule

// File: design/lbus_seg_buffer.sv
/*
  lbus segment buffer
  circular store of input beats, one credit back per pop, keeps last popped beat
*/
`timescale 1ns/1ns

module lbus_seg_buffer
  import lbus_align_pkg::*;
#(
  parameter int BUF_DEPTH = BUF_DEPTH_DEF  // power of two, at least 2
) (
  input  logic       CLK,
  input  logic       user_rst,
  input  logic       in_valid,
  input  lbus_beat_t in_beat,
  input  logic       pop,
  output logic       head_valid,
  output lbus_beat_t head_beat,
  output lbus_beat_t prev_beat,
  output logic       in_credit
);

  localparam int AW = $clog2(BUF_DEPTH);

  lbus_beat_t  mem [BUF_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;

  assign head_valid = wr_ptr != rd_ptr;
  assign full       = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign head_beat  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge CLK) begin
    if (in_valid) begin
      mem[wr_ptr[AW-1:0]] <= in_beat;
    end
  end

  // history for the shifter, lanes left over from the beat just consumed
  always_ff @(posedge CLK) begin
    if (pop) begin
      prev_beat <= head_beat;
    end
  end

  always_ff @(posedge CLK or posedge user_rst) begin
    if (user_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      in_credit <= pop;  // slot freed, credit back to source
    end
  end

  // source must spend a credit per beat
  a_no_overflow: assert property (@(posedge CLK) disable iff (user_rst)
    in_valid |-> !full)
    else $error("write into full segment buffer, source overran its credits");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the lbus aligner simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_lbus_aligner -o sim_lbus
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_lbus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit 0

// File: verification/lbus_align_checker.sv
/*
  lbus aligner checker
  repacks observed input beats into expected output beats and compares
*/
`timescale 1ns/1ns

module lbus_align_checker
  import lbus_align_pkg::*;
#(
  parameter int BUF_DEPTH = BUF_DEPTH_DEF
) (
  input  logic       CLK,
  input  logic       user_rst,
  input  int         test_id,
  input  logic       in_valid,
  input  lbus_beat_t in_beat,
  input  logic       in_credit,
  input  logic       out_credit,
  input  logic       out_valid,
  input  lbus_beat_t out_beat,
  output int         mismatch_cnt,
  output int         unexpected_cnt,
  output int         credit_err_cnt,
  output int         pending
);

  lbus_beat_t exp_q [$];
  int         tid_q [$];
  lbus_beat_t part;      // output beat being filled
  int         fill;
  int         src_credits;
  int         out_credits;  // downstream grants not yet spent

  // place one valid segment, return 1 when the beat is closed
  function automatic logic add_segment(input lbus_beat_t part_in, input int fill_in,
                                       input lbus_seg_t seg, output lbus_beat_t part_out,
                                       output int fill_out);
    part_out          = part_in;
    part_out[fill_in] = seg;
    fill_out          = fill_in + 1;
    return (fill_out == NUM_SEG) || seg.eop || seg.err;
  endfunction

  function automatic string test_name(int id);
    case (id)
      1:       return "aligned";
      2:       return "offset";
      3:       return "mixed";
      4:       return "stall";
      default: return "none";
    endcase
  endfunction

  always @(posedge CLK or posedge user_rst) begin
    lbus_beat_t nxt_part;
    int         nxt_fill;
    lbus_beat_t exp;
    int         tid;
    if (user_rst) begin
      exp_q.delete();
      tid_q.delete();
      part           = '0;
      fill           = 0;
      src_credits    = BUF_DEPTH;
      out_credits    = 0;
      mismatch_cnt   = 0;
      unexpected_cnt = 0;
      credit_err_cnt = 0;
      pending        = 0;
    end else begin
      if (in_valid) begin
        if (src_credits == 0) begin
          credit_err_cnt++;
          $display("source sent a beat without holding an input credit");
        end else begin
          src_credits--;
        end
        for (int i = 0; i < NUM_SEG; i++) begin
          if (in_beat[i].en) begin
            if (in_beat[i].sop && fill != 0) begin  // open beat cut short by a new packet
              exp_q.push_back(part);
              tid_q.push_back(test_id);
              part = '0;
              fill = 0;
            end
            if (add_segment(part, fill, in_beat[i], nxt_part, nxt_fill)) begin
              exp_q.push_back(nxt_part);
              tid_q.push_back(test_id);
              part = '0;
              fill = 0;
            end else begin
              part = nxt_part;
              fill = nxt_fill;
            end
          end
        end
      end
      if (in_credit) begin
        src_credits++;
        if (src_credits > BUF_DEPTH) begin
          credit_err_cnt++;
          $display("DUT returned more input credits than the buffer holds");
        end
      end
      if (out_valid) begin
        if (out_credits == 0) begin
          credit_err_cnt++;
          $display("DUT sent an output beat without holding a downstream credit");
        end else begin
          out_credits--;
        end
        if (exp_q.size() == 0) begin
          unexpected_cnt++;
          $display("output beat %h arrived with no expected beat queued", out_beat);
        end else begin
          exp = exp_q.pop_front();
          tid = tid_q.pop_front();
          if (out_beat !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH test=%s expected=%h actual=%h", test_name(tid), exp, out_beat);
          end
        end
      end
      if (out_credit) out_credits++;
      pending = exp_q.size();
    end
  end

endmodule

// File: verification/tb_lbus_aligner.sv
/*
  lbus aligner testbench
  random packet source under credits, downstream credit driver, watchdog
*/
`timescale 1ns/1ns

module tb_lbus_aligner
  import lbus_align_pkg::*;
();

  localparam int BUF_DEPTH = 8;
  localparam int STALL_CYC = 80;

  logic        CLK;
  logic        user_rst;
  logic        in_valid;
  lbus_beat_t  in_beat;
  logic        in_credit;
  logic        out_credit;
  logic        out_valid;
  lbus_beat_t  out_beat;
  int          test_id;
  int          mismatch_cnt;
  int          unexpected_cnt;
  int          credit_err_cnt;
  int          pending;

  lbus_beat_t  beat_q [$];
  int          phase_q [$];
  lbus_beat_t  cur;
  int          pos;
  logic        cur_sop;
  logic [31:0] seed;
  logic [31:0] cseed;
  logic        gen_done;
  int          src_credits;
  int          granted;
  int          received;
  int          stall_cnt;
  int          limit;

  lbus_aligner_top #(.SEG_W(SEG_W_DEF), .BUF_DEPTH(BUF_DEPTH)) dut (
    .CLK(CLK), .user_rst(user_rst), .in_valid(in_valid), .in_beat(in_beat),
    .in_credit(in_credit), .out_credit(out_credit), .out_valid(out_valid),
    .out_beat(out_beat)
  );

  lbus_align_checker #(.BUF_DEPTH(BUF_DEPTH)) chk (
    .CLK(CLK), .user_rst(user_rst), .test_id(test_id), .in_valid(in_valid),
    .in_beat(in_beat), .in_credit(in_credit), .out_credit(out_credit),
    .out_valid(out_valid), .out_beat(out_beat),
    .mismatch_cnt(mismatch_cnt), .unexpected_cnt(unexpected_cnt),
    .credit_err_cnt(credit_err_cnt), .pending(pending)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function int next_rand(input int n);
    seed = lcg(seed);
    return int'(seed[30:16]) % n;
  endfunction

  task push_beat(input int ph);
    if (pos > 0) begin
      beat_q.push_back(cur);
      phase_q.push_back(ph);
    end
    cur     = '0;
    pos     = 0;
    cur_sop = 1'b0;
  endtask

  task put_seg(input lbus_seg_t s, input int ph);
    cur[pos] = s;
    pos++;
    if (s.sop) cur_sop = 1'b1;
    if (pos == NUM_SEG) push_beat(ph);
  endtask

  // kind 0 starts at lane 0, kind 1 at lanes 1..3, kind 2 anywhere
  task add_packet(input int kind, input int ph);
    int        len;
    int        gap;
    lbus_seg_t s;
    gap = 0;
    if (kind != 2) push_beat(ph);
    if (kind == 1) gap = 1 + next_rand(3);
    if (kind == 2) gap = next_rand(3);
    for (int i = 0; i < gap; i++) put_seg('0, ph);
    while (cur_sop) put_seg('0, ph);  // one sop per beat
    len = 1 + next_rand(9);
    for (int i = 0; i < len; i++) begin
      s      = '0;
      s.en   = 1'b1;
      s.sop  = (i == 0);
      seed   = lcg(seed);
      s.data = seed;
      if (i == len - 1) begin
        s.err = (next_rand(5) == 0);
        s.eop = !s.err;
        s.mty = 4'(next_rand(16));
      end
      put_seg(s, ph);
    end
  endtask

  task print_counts();
    $display("errors: mismatch=%0d unexpected=%0d credit=%0d pending=%0d",
             mismatch_cnt, unexpected_cnt, credit_err_cnt, pending);
  endtask

  // downstream grants, never more than BUF_DEPTH outstanding
  always @(posedge CLK) begin
    cseed = lcg(cseed);
    if (out_valid) received++;
    if (user_rst || (test_id == 4 && stall_cnt < STALL_CYC)) begin
      if (!user_rst) stall_cnt++;
      out_credit <= 1'b0;
    end else if (granted - received < BUF_DEPTH && cseed[20:19] != 2'b00) begin
      granted++;
      out_credit <= 1'b1;
    end else begin
      out_credit <= 1'b0;
    end
  end

  initial begin
    in_valid   = 1'b0;
    in_beat    = '0;
    out_credit = 1'b0;
    user_rst   = 1'b1;
    test_id    = 0;
    gen_done   = 1'b0;
    granted    = 0;
    received   = 0;
    stall_cnt  = 0;
    seed       = 32'h9fda;
    cseed      = lcg(32'h9fda);
    cur        = '0;
    pos        = 0;
    cur_sop    = 1'b0;
    for (int i = 0; i < 12; i++) add_packet(0, 1);
    push_beat(1);
    for (int i = 0; i < 12; i++) add_packet(1, 2);
    push_beat(2);
    for (int i = 0; i < 30; i++) add_packet(2, 3);
    push_beat(3);
    for (int i = 0; i < 20; i++) add_packet(2, 4);
    push_beat(4);
    limit    = beat_q.size() * NUM_SEG * 4 + STALL_CYC + 500;
    gen_done = 1'b1;
    repeat (16) @(posedge CLK);
    user_rst    <= 1'b0;
    src_credits = BUF_DEPTH;
    while (beat_q.size() > 0) begin
      @(posedge CLK);
      if (in_credit) src_credits++;
      if (src_credits > 0 && next_rand(4) != 0) begin
        in_valid <= 1'b1;
        in_beat  <= beat_q.pop_front();
        test_id  <= phase_q.pop_front();
        src_credits--;
      end else begin
        in_valid <= 1'b0;
      end
    end
    @(posedge CLK);
    in_valid <= 1'b0;
    repeat (4) @(posedge CLK);
    while (pending != 0) @(negedge CLK);
    repeat (20) @(negedge CLK);  // catch stray extra beats
    print_counts();
    if (mismatch_cnt + unexpected_cnt + credit_err_cnt + pending == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    wait (gen_done);
    repeat (limit + 16) @(posedge CLK);
    $display("timeout, %0d expected beats never came out of the DUT", pending);
    print_counts();
    $display("Result: FAILED");
    $finish;
  end

endmodule
